// ==== design/lsuPkg.sv ====
package lsuPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN  = 32;                  // Data and address width
  localparam int BYTES = XLEN / 8;            // Byte lanes per word

  localparam int FUNCT3_UNSIGNED = 2;         // Funct3 bit that selects zero extension

  ////////////////////////////////////////////////////////////////////////////
  // Command and size encodings
  ////////////////////////////////////////////////////////////////////////////

  // Read in the upper bit, write in the lower bit, idle is all zero
  typedef struct packed {
    logic read;                               // Load in this stage
    logic write;                              // Store in this stage
  } memRwT;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,                        // lb, lbu, sb
    SIZE_HALF = 2'b01,                        // lh, lhu, sh
    SIZE_WORD = 2'b10                         // lw, sw
  } accessSizeT;

  // Reverse the byte order of a word, shared by the load and the store path
  function automatic logic [XLEN-1:0] byteSwap(input logic [XLEN-1:0] word);
    logic [XLEN-1:0] swapped;
    for (int i = 0; i < BYTES; i++) begin
      swapped[8*i +: 8] = word[XLEN-8*(i+1) +: 8];  // Lane i takes mirrored lane
    end
    return swapped;
  endfunction

endpackage

// ==== design/dtimReqIf.sv ====
`timescale 1ns/1ps

// Write request from the memory stage into the DTIM
// Masked bytes are written at the rising edge while writeEn is high
interface dtimReqIf import lsuPkg::*; #(
  parameter int DtimWords = 256               // Words in the DTIM, power of two
);
  localparam int AdrBits = $clog2(DtimWords);

  logic [AdrBits-1:0] wordAdr;                // Word index in the DTIM
  logic [BYTES-1:0]   byteMask;               // One bit per byte lane
  logic [XLEN-1:0]    writeData;              // Formatted store data
  logic               writeEn;                // Commit the store this edge

  modport ctrl (
    output wordAdr, byteMask, writeData, writeEn
  );

  modport mem (
    input  wordAdr, byteMask, writeData, writeEn
  );

endinterface

// ==== design/storeFormat.sv ====
`timescale 1ns/1ps

module storeFormat import lsuPkg::*; (
  input  logic [1:0]       adrLow,            // Byte offset in the word
  input  accessSizeT       size,              // Store size
  input  logic             BigEndianM,        // Swap byte order
  input  logic [XLEN-1:0]  WriteDataM,        // Raw store data
  output logic [BYTES-1:0] byteMask,          // Lanes to write
  output logic [XLEN-1:0]  writeData          // Data placed on every lane
);

  logic [XLEN-1:0] replicated;                // Subword copied across the word

  // Copy the subword into every lane it may land in
  always_comb begin
    case (size)
      SIZE_BYTE: replicated = {4{WriteDataM[7:0]}};
      SIZE_HALF: replicated = {2{WriteDataM[15:0]}};
      default:   replicated = WriteDataM;     // Word passes unchanged
    endcase
  end

  // MSB of the store ends up at the lowest address in big-endian mode
  assign writeData = BigEndianM ? byteSwap(replicated) : replicated;

  ////////////////////////////////////////////////////////////////////////////
  // Byte mask from address and size
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (size)
      SIZE_BYTE: byteMask = 4'b0001 << adrLow;              // Single lane
      SIZE_HALF: byteMask = adrLow[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
      default:   byteMask = 4'b1111;                        // Whole word
    endcase
  end

endmodule

// ==== design/memStageCtrl.sv ====
`timescale 1ns/1ps

module memStageCtrl import lsuPkg::*; #(
  parameter int DtimWords = 256               // Words in the DTIM, power of two
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            StallM,             // Hold the M stage
  input  logic            FlushM,             // Bubble into the M stage
  input  logic            FlushW,             // Kill the store leaving M
  input  logic [XLEN-1:0] IEUAdrE,            // Execute stage address
  input  memRwT           MemRWM,             // Memory stage command
  input  logic [2:0]      Funct3M,            // Size and signedness
  input  logic [XLEN-1:0] WriteDataM,         // Raw store data from the IEU
  input  logic            BigEndianM,         // Swap byte order
  output logic [XLEN-1:0] IEUAdrM,            // Memory stage address
  output logic            LoadMisalignedFaultM,
  output logic            StoreAmoMisalignedFaultM,
  dtimReqIf.ctrl          req                 // Write port of the DTIM
);

  localparam int AdrBits = $clog2(DtimWords);

  accessSizeT size;                           // Access size in M
  logic       misalignedM;                    // Address not aligned to size

  ////////////////////////////////////////////////////////////////////////////
  // E to M address register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      IEUAdrM <= '0;
    end else if (!StallM) begin
      if (FlushM) begin
        IEUAdrM <= '0;                        // Flushed slot carries no address
      end else begin
        IEUAdrM <= IEUAdrE;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Misalignment and store gating
  ////////////////////////////////////////////////////////////////////////////

  assign size = accessSizeT'(Funct3M[1:0]);

  always_comb begin
    case (size)
      SIZE_BYTE: misalignedM = 1'b0;          // Bytes are always aligned
      SIZE_HALF: misalignedM = IEUAdrM[0];    // Odd halfword address
      default:   misalignedM = |IEUAdrM[1:0]; // Word off a 4 byte boundary
    endcase
  end

  assign LoadMisalignedFaultM     = MemRWM.read & misalignedM;
  assign StoreAmoMisalignedFaultM = MemRWM.write & misalignedM;

  // Only an aligned store that survives the W flush reaches the memory
  assign req.writeEn = MemRWM.write & ~misalignedM & ~FlushW;
  assign req.wordAdr = IEUAdrM[2 +: AdrBits]; // Upper bits wrap modulo DtimWords

  storeFormat storeFormat_i (
    .adrLow     (IEUAdrM[1:0]),
    .size       (size),
    .BigEndianM (BigEndianM),
    .WriteDataM (WriteDataM),
    .byteMask   (req.byteMask),
    .writeData  (req.writeData)
  );

endmodule

// ==== design/dtim.sv ====
`timescale 1ns/1ps

module dtim import lsuPkg::*; #(
  parameter int DtimWords = 256               // Words in the DTIM, power of two
) (
  input  logic            clk,
  input  logic            ce,                 // Read register enable
  input  logic [XLEN-1:0] readAdr,            // Execute stage address
  dtimReqIf.mem           req,                // Write request from M
  output logic [XLEN-1:0] readWord            // Registered read word
);

  localparam int AdrBits = $clog2(DtimWords);

  logic [BYTES-1:0][7:0] mem [DtimWords];     // Byte lane storage
  logic [AdrBits-1:0]    readIdx;             // Word index of the load
  logic                  sameWord;            // Store and load hit one word

  assign readIdx  = readAdr[2 +: AdrBits];
  assign sameWord = req.writeEn & (req.wordAdr == readIdx);

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (req.writeEn) begin
      for (int b = 0; b < BYTES; b++) begin
        if (req.byteMask[b]) begin
          mem[req.wordAdr][b] <= req.writeData[8*b +: 8];  // Masked lane only
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port with write to read bypass
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ce) begin
      for (int b = 0; b < BYTES; b++) begin
        if (sameWord && req.byteMask[b]) begin
          readWord[8*b +: 8] <= req.writeData[8*b +: 8];   // New byte from the store
        end else begin
          readWord[8*b +: 8] <= mem[readIdx][b];           // Stored byte
        end
      end
    end
  end

endmodule

// ==== design/loadFormat.sv ====
`timescale 1ns/1ps

module loadFormat import lsuPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            StallW,             // Hold the W stage
  input  logic [XLEN-1:0] readWord,           // Word read from the DTIM
  input  logic [1:0]      adrLow,             // Byte offset in the word
  input  logic [2:0]      Funct3M,            // Size and signedness
  input  logic            BigEndianM,         // Swap byte order
  output logic [XLEN-1:0] ReadDataW           // Load result to writeback
);

  logic [XLEN-1:0] leWord;                    // Word in little-endian order
  logic [1:0]      laneAdr;                   // Offset after the swap
  logic [7:0]      byteM;                     // Addressed byte
  logic [15:0]     halfM;                     // Addressed halfword
  logic            unsignedM;                 // Zero extend
  logic [XLEN-1:0] ReadDataM;                 // Extended load result

  // Swapping the word mirrors the lanes, so the offset is mirrored too
  assign leWord  = BigEndianM ? byteSwap(readWord) : readWord;
  assign laneAdr = adrLow ^ {2{BigEndianM}};

  assign byteM = leWord[8*laneAdr +: 8];
  assign halfM = leWord[16*laneAdr[1] +: 16];

  assign unsignedM = Funct3M[FUNCT3_UNSIGNED];

  ////////////////////////////////////////////////////////////////////////////
  // Subword select and extension
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (accessSizeT'(Funct3M[1:0]))
      SIZE_BYTE: ReadDataM = {{(XLEN-8){byteM[7] & ~unsignedM}}, byteM};
      SIZE_HALF: ReadDataM = {{(XLEN-16){halfM[15] & ~unsignedM}}, halfM};
      default:   ReadDataM = leWord;          // Full word
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // M to W read data register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      ReadDataW <= '0;
    end else if (!StallW) begin
      ReadDataW <= ReadDataM;                 // Holds while W is stalled
    end
  end

endmodule

// ==== design/lsu.sv ====
`timescale 1ns/1ps

module lsu import lsuPkg::*; #(
  parameter int DtimWords = 256               // Words in the DTIM, power of two
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            StallM,
  input  logic            FlushM,
  input  logic            StallW,
  input  logic            FlushW,
  input  memRwT           MemRWE,             // Execute stage command
  input  memRwT           MemRWM,             // Memory stage command
  input  logic [2:0]      Funct3M,            // Size and signedness
  input  logic [XLEN-1:0] IEUAdrE,            // Execute stage address
  input  logic [XLEN-1:0] WriteDataM,         // Store data
  input  logic            BigEndianM,         // Swap byte order
  output logic [XLEN-1:0] IEUAdrM,            // Memory stage address
  output logic [XLEN-1:0] ReadDataW,          // Load result
  output logic            LoadMisalignedFaultM,
  output logic            StoreAmoMisalignedFaultM
);

  logic            dtimCe;                    // Capture a new read word
  logic [XLEN-1:0] readWordM;                 // DTIM read data in M

  dtimReqIf #(.DtimWords(DtimWords)) dtimReq ();

  // Only a load in E with W free updates the read register
  assign dtimCe = ~StallW & MemRWE.read;

  memStageCtrl #(.DtimWords(DtimWords)) memStageCtrl_i (
    .clk                      (clk),
    .reset                    (reset),
    .StallM                   (StallM),
    .FlushM                   (FlushM),
    .FlushW                   (FlushW),
    .IEUAdrE                  (IEUAdrE),
    .MemRWM                   (MemRWM),
    .Funct3M                  (Funct3M),
    .WriteDataM               (WriteDataM),
    .BigEndianM               (BigEndianM),
    .IEUAdrM                  (IEUAdrM),
    .LoadMisalignedFaultM     (LoadMisalignedFaultM),
    .StoreAmoMisalignedFaultM (StoreAmoMisalignedFaultM),
    .req                      (dtimReq.ctrl)
  );

  dtim #(.DtimWords(DtimWords)) dtim_i (
    .clk      (clk),
    .ce       (dtimCe),
    .readAdr  (IEUAdrE),                      // Read starts in E
    .req      (dtimReq.mem),
    .readWord (readWordM)
  );

  loadFormat loadFormat_i (
    .clk        (clk),
    .reset      (reset),
    .StallW     (StallW),
    .readWord   (readWordM),
    .adrLow     (IEUAdrM[1:0]),
    .Funct3M    (Funct3M),
    .BigEndianM (BigEndianM),
    .ReadDataW  (ReadDataW)
  );

endmodule

// ==== sim/lsuTb.sv ====
`timescale 1ns/1ps

module lsuTb import lsuPkg::*; ();

  localparam int    Words      = 256;         // DTIM size under test
  localparam int    CycleLimit = 2000;        // Run takes about 250 cycles
  localparam memRwT Idle       = 2'b00;
  localparam memRwT Rd         = 2'b10;
  localparam memRwT Wr         = 2'b01;

  logic            clk = 1'b0;
  logic            reset, StallM, FlushM, StallW, FlushW, BigEndianM;
  memRwT           MemRWE, MemRWM;
  logic [2:0]      Funct3M;
  logic [XLEN-1:0] IEUAdrE, WriteDataM, IEUAdrM, ReadDataW;
  logic            LoadMisalignedFaultM, StoreAmoMisalignedFaultM;

  logic [7:0]      model [Words*4];           // Byte array reference
  int              errors = 0;
  int              cycles = 0;
  memRwT           mRw;                       // Op waiting in the M stage
  logic [2:0]      mF3;
  logic [XLEN-1:0] mAdr, mData;
  logic            mBe;

  lsu #(.DtimWords(Words)) lsu_i (
    .clk                      (clk),
    .reset                    (reset),
    .StallM                   (StallM),
    .FlushM                   (FlushM),
    .StallW                   (StallW),
    .FlushW                   (FlushW),
    .MemRWE                   (MemRWE),
    .MemRWM                   (MemRWM),
    .Funct3M                  (Funct3M),
    .IEUAdrE                  (IEUAdrE),
    .WriteDataM               (WriteDataM),
    .BigEndianM               (BigEndianM),
    .IEUAdrM                  (IEUAdrM),
    .ReadDataW                (ReadDataW),
    .LoadMisalignedFaultM     (LoadMisalignedFaultM),
    .StoreAmoMisalignedFaultM (StoreAmoMisalignedFaultM)
  );

  always #20 clk = ~clk;                      // 40 ns period

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout: no end of test after %0d cycles, %0d errors", cycles, errors);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic int idx(input logic [XLEN-1:0] adr);
    return int'(adr % (Words * 4));           // Memory wraps at its size
  endfunction

  function automatic logic misaligned(input logic [2:0] f3, input logic [XLEN-1:0] adr);
    return (adr % (1 << f3[1:0])) != 0;
  endfunction

  // Lowest address holds the LSB or in big-endian mode the MSB
  function automatic logic [XLEN-1:0] expectLoad(input logic [2:0] f3,
                                                 input logic [XLEN-1:0] adr, input logic be);
    int              n;
    logic [XLEN-1:0] v;
    n = 1 << f3[1:0];
    v = '0;
    for (int i = 0; i < n; i++) begin
      if (be) v[8*(n-1-i) +: 8] = model[idx(adr + i)];
      else v[8*i +: 8] = model[idx(adr + i)];
    end
    if (!f3[FUNCT3_UNSIGNED] && n < BYTES && v[8*n-1])
      v = v | ({XLEN{1'b1}} << (8 * n));      // Sign extension
    return v;
  endfunction

  task automatic storeModel(input logic [2:0] f3, input logic [XLEN-1:0] adr,
                            input logic [XLEN-1:0] data, input logic be);
    int n;
    n = 1 << f3[1:0];
    for (int i = 0; i < n; i++) begin
      model[idx(adr + i)] = be ? data[8*(n-1-i) +: 8] : data[8*i +: 8];
    end
  endtask

  task automatic flagError(input string msg);
    errors++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  // Random address in the prefilled 16 word window aligned to the size
  function automatic logic [XLEN-1:0] randAdr(input logic [1:0] size);
    logic [XLEN-1:0] a;
    a = $urandom();
    a[$clog2(Words)+1:6] = '0;
    a = a & ~((32'd1 << size) - 1);
    return a;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // One cycle with a new op in E while the previous op is in M
  ////////////////////////////////////////////////////////////////////////////

  task automatic step(input memRwT rw, input logic [XLEN-1:0] adr, input logic [2:0] f3,
                      input logic [XLEN-1:0] data, input logic be);
    logic            mis;
    logic [XLEN-1:0] expData;
    mis        = misaligned(mF3, mAdr);
    expData    = expectLoad(mF3, mAdr, mBe);  // Model holds every earlier store
    MemRWE     = rw;
    IEUAdrE    = adr;
    MemRWM     = mRw;
    Funct3M    = mF3;
    WriteDataM = mData;
    BigEndianM = mBe;
    @(negedge clk);                           // Faults settle mid cycle
    if (IEUAdrM !== mAdr)
      flagError($sformatf("IEUAdrM %h, expected %h", IEUAdrM, mAdr));
    if (LoadMisalignedFaultM !== (mRw.read & mis))
      flagError($sformatf("load fault %b at %h f3 %b", LoadMisalignedFaultM, mAdr, mF3));
    if (StoreAmoMisalignedFaultM !== (mRw.write & mis))
      flagError($sformatf("store fault %b at %h f3 %b", StoreAmoMisalignedFaultM, mAdr, mF3));
    @(posedge clk);
    #2;
    if (mRw.write && !mis && !FlushW) storeModel(mF3, mAdr, mData, mBe);
    if (mRw.read && !mis && ReadDataW !== expData)
      flagError($sformatf("load f3 %b at %h be %b: ReadDataW %h, expected %h",
                          mF3, mAdr, mBe, ReadDataW, expData));
    mRw   = rw;
    mF3   = f3;
    mAdr  = adr;
    mData = data;
    mBe   = be;
  endtask

  task automatic drain();
    repeat (2) step(Idle, '0, 3'b010, '0, 1'b0);
  endtask

  task automatic loadAll(input logic [XLEN-1:0] base);
    for (int be = 0; be < 2; be++) begin
      for (int off = 0; off < 4; off++) begin
        step(Rd, base + off, 3'b000, '0, be[0]);   // lb
        step(Rd, base + off, 3'b100, '0, be[0]);   // lbu
      end
      for (int off = 0; off < 4; off += 2) begin
        step(Rd, base + off, 3'b001, '0, be[0]);   // lh
        step(Rd, base + off, 3'b101, '0, be[0]);   // lhu
      end
      step(Rd, base, 3'b010, '0, be[0]);           // lw
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic wordTest();
    logic [XLEN-1:0] adr;
    for (int k = 0; k < 8; k++) begin
      adr = randAdr(2);
      step(Wr, adr, 3'b010, $urandom(), 1'b0);
      step(Rd, randAdr(2), 3'b010, '0, 1'b0);
      step(Rd, adr, 3'b010, '0, 1'b0);
    end
    drain();
  endtask

  task automatic subwordTest(input logic be);
    logic [XLEN-1:0] base;
    base = randAdr(2);
    step(Wr, base, 3'b010, 32'hf08a_7f15, be);
    step(Wr, base + 1, 3'b000, 32'h0000_0096, be);  // sb
    step(Wr, base + 2, 3'b001, 32'h0000_81c4, be);  // sh
    loadAll(base);
    drain();
  endtask

  task automatic misalignTest();
    logic [XLEN-1:0] base;
    base = randAdr(2);
    for (int off = 1; off < 4; off++) begin
      step(Wr, base + off, 3'b010, $urandom(), 1'b0);
      step(Rd, base + off, 3'b010, '0, 1'b0);
      if (off != 2) begin
        step(Wr, base + off, 3'b001, $urandom(), 1'b0);
        step(Rd, base + off, 3'b101, '0, 1'b0);
      end
    end
    step(Rd, base, 3'b010, '0, 1'b0);         // Word must be unchanged
    drain();
  endtask

  task automatic addressCycle(input logic [XLEN-1:0] adr, input logic stall,
                              input logic flush, input logic [XLEN-1:0] expAdr);
    MemRWE  = Idle;
    MemRWM  = Idle;
    IEUAdrE = adr;
    StallM  = stall;
    FlushM  = flush;
    @(posedge clk);
    #2;
    if (IEUAdrM !== expAdr)
      flagError($sformatf("IEUAdrM %h after stall %b flush %b, expected %h",
                          IEUAdrM, stall, flush, expAdr));
    StallM = 1'b0;
    FlushM = 1'b0;
    mRw    = Idle;
    mAdr   = expAdr;
  endtask

  task automatic flushStallTest();
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] held;
    adr = randAdr(2);
    step(Wr, adr, 3'b010, 32'h5ee0_d1ed, 1'b0);
    FlushW = 1'b1;
    step(Idle, adr, 3'b010, '0, 1'b0);        // Store leaves M while flushed
    FlushW = 1'b0;
    step(Rd, adr, 3'b010, '0, 1'b0);
    step(Idle, adr, 3'b010, '0, 1'b0);
    held   = ReadDataW;
    StallW = 1'b1;
    for (int c = 0; c < 3; c++) begin
      MemRWE  = Rd;                           // Busy E and M while W must hold
      MemRWM  = Rd;
      Funct3M = 3'(c);
      @(posedge clk);
      #2;
      if (ReadDataW !== held)
        flagError($sformatf("ReadDataW %h moved under StallW, held %h", ReadDataW, held));
    end
    StallW = 1'b0;
    addressCycle(32'h1234_5678, 1'b0, 1'b0, 32'h1234_5678);
    addressCycle(32'h0bad_cafe, 1'b1, 1'b0, 32'h1234_5678);
    addressCycle(32'h0bad_cafe, 1'b1, 1'b1, 32'h1234_5678);  // Stall wins
    addressCycle(32'h0bad_cafe, 1'b0, 1'b1, '0);
    drain();
  endtask

  task automatic randomTest();
    memRwT           rw;
    logic [1:0]      size;
    logic [XLEN-1:0] adr;
    adr = randAdr(2);
    step(Wr, adr, 3'b010, $urandom(), 1'b0);
    step(Rd, adr, 3'b010, '0, 1'b0);          // Reads through the bypass
    step(Wr, adr + 3, 3'b000, $urandom(), 1'b0);
    step(Rd, adr, 3'b010, '0, 1'b0);
    step(Wr, adr + 2, 3'b001, $urandom(), 1'b1);
    step(Rd, adr, 3'b010, '0, 1'b0);
    for (int k = 0; k < 100; k++) begin
      rw   = $urandom_range(1) ? Rd : Wr;
      size = 2'($urandom_range(2));
      step(rw, randAdr(size), {rw.read & 1'($urandom_range(1)), size}, $urandom(),
           1'($urandom_range(1)));
    end
    drain();
  endtask

  initial begin
    void'($urandom(32'hb8d8_d3bd));
    reset      = 1'b1;
    StallM     = 1'b0;
    FlushM     = 1'b0;
    StallW     = 1'b0;
    FlushW     = 1'b0;
    MemRWE     = Idle;
    MemRWM     = Idle;
    Funct3M    = 3'b010;
    IEUAdrE    = 32'hffff_fffc;               // Reset overrides this address
    WriteDataM = '0;
    BigEndianM = 1'b0;
    mRw        = Idle;
    mF3        = 3'b010;
    mAdr       = '0;
    mData      = '0;
    mBe        = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    if (IEUAdrM !== '0 || ReadDataW !== '0)
      flagError($sformatf("after reset IEUAdrM %h ReadDataW %h", IEUAdrM, ReadDataW));
    for (int w = 0; w < 16; w++) begin        // Fill the test window
      step(Wr, XLEN'(w * 4), 3'b010, (XLEN'(w * 4) * 32'h9e37_79b9) ^ 32'h3c5a_96e1, 1'b0);
    end
    wordTest();
    subwordTest(1'b0);
    subwordTest(1'b1);
    misalignTest();
    flushStallTest();
    randomTest();
    $display("Run finished after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
design/lsuPkg.sv
design/dtimReqIf.sv
design/storeFormat.sv
design/memStageCtrl.sv
design/dtim.sv
design/loadFormat.sv
design/lsu.sv
sim/lsuTb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - design/lsuPkg.sv
  - design/dtimReqIf.sv
  - design/storeFormat.sv
  - design/memStageCtrl.sv
  - design/dtim.sv
  - design/loadFormat.sv
  - design/lsu.sv
  - target: simulation
    files:
      - sim/lsuTb.sv
